//--- compile.f
design/gpio_pkg.sv
design/gpio_apb_regs.sv
design/gpio_in_sync.sv
design/gpio_irq.sv
design/apb_gpio.sv
sim/tb_apb_gpio.sv

//--- design/apb_gpio.sv
// Top level of the 32-pad APB GPIO peripheral, connecting the register, sync and interrupt blocks
`timescale 1ns/10ps

module apb_gpio
    import gpio_pkg::*;
(
    input  logic                      HCLK,
    input  logic                      HRESETn,

    input  logic [APB_ADDR_WIDTH-1:0] PADDR,
    input  pad_vec_t                  PWDATA,
    input  logic                      PWRITE,
    input  logic                      PSEL,
    input  logic                      PENABLE,
    output pad_vec_t                  PRDATA,
    output logic                      PREADY,
    output logic                      PSLVERR,

    input  pad_vec_t                  gpio_in,
    output pad_vec_t                  gpio_in_sync,
    output pad_vec_t                  gpio_out,
    output pad_vec_t                  gpio_dir,
    output logic                      interrupt
);

    gpio_cfg_t cfg;
    logic      status_rd;
    pad_vec_t  status;
    pad_vec_t  sync_in;
    pad_vec_t  held_in;
    pad_vec_t  rise;
    pad_vec_t  fall;

    gpio_apb_regs regs_i (
        .HCLK      (HCLK),
        .HRESETn   (HRESETn),
        .PADDR     (PADDR),
        .PWDATA    (PWDATA),
        .PWRITE    (PWRITE),
        .PSEL      (PSEL),
        .PENABLE   (PENABLE),
        .PRDATA    (PRDATA),
        .held_in   (held_in),
        .status    (status),
        .cfg       (cfg),
        .status_rd (status_rd)
    );

    gpio_in_sync sync_i (
        .HCLK    (HCLK),
        .HRESETn (HRESETn),
        .gpio_in (gpio_in),
        .en      (cfg.en),
        .sync_in (sync_in),
        .held_in (held_in),
        .rise    (rise),
        .fall    (fall)
    );

    gpio_irq irq_i (
        .HCLK      (HCLK),
        .HRESETn   (HRESETn),
        .cfg       (cfg),
        .rise      (rise),
        .fall      (fall),
        .status_rd (status_rd),
        .status    (status),
        .interrupt (interrupt)
    );

    assign gpio_in_sync = sync_in;
    assign gpio_out     = cfg.out;
    assign gpio_dir     = cfg.dir;

    assign PREADY  = 1'b1;  // Zero-wait slave
    assign PSLVERR = 1'b0;

endmodule

//--- design/gpio_apb_regs.sv
// APB register block of the GPIO: decodes accesses, holds the configuration and muxes read data
`timescale 1ns/10ps

module gpio_apb_regs
    import gpio_pkg::*;
(
    input  logic                      HCLK,
    input  logic                      HRESETn,

    input  logic [APB_ADDR_WIDTH-1:0] PADDR,
    input  pad_vec_t                  PWDATA,
    input  logic                      PWRITE,
    input  logic                      PSEL,
    input  logic                      PENABLE,
    output pad_vec_t                  PRDATA,

    input  pad_vec_t                  held_in,
    input  pad_vec_t                  status,

    output gpio_cfg_t                 cfg,
    output logic                      status_rd
);

    logic [REG_ADDR_WIDTH-1:0] reg_idx;
    logic                      wr_access;
    logic                      rd_access;
    gpio_cfg_t                 cfg_q;

    assign reg_idx   = PADDR[6:2];
    assign wr_access = PSEL && PENABLE && PWRITE;
    assign rd_access = PSEL && PENABLE && !PWRITE;

    // Strobe that tells the interrupt block to clear its status
    assign status_rd = rd_access && (reg_idx == REG_INTSTATUS);

    assign cfg = cfg_q;

    always_ff @(posedge HCLK or negedge HRESETn)
    begin
        if (!HRESETn)
        begin
            cfg_q <= '0;
        end
        else if (wr_access)
        begin
            case (reg_idx)
                REG_PADDIR:
                begin
                    cfg_q.dir <= PWDATA;
                end
                REG_GPIOEN:
                begin
                    cfg_q.en <= PWDATA;
                end
                REG_PADOUT:
                begin
                    cfg_q.out <= PWDATA;
                end
                REG_PADOUTSET:
                begin
                    cfg_q.out <= cfg_q.out | PWDATA;  // Atomic set
                end
                REG_PADOUTCLR:
                begin
                    cfg_q.out <= cfg_q.out & ~PWDATA;  // Atomic clear
                end
                REG_INTEN:
                begin
                    cfg_q.inten <= PWDATA;
                end
                REG_INTTYPE_LO:
                begin
                    cfg_q.inttype[15:0] <= PWDATA;  // Two bits per pad
                end
                REG_INTTYPE_HI:
                begin
                    cfg_q.inttype[31:16] <= PWDATA;
                end
                default:
                begin
                    cfg_q <= cfg_q;  // PADIN, INTSTATUS and holes are read only
                end
            endcase
        end
    end

    // Zero-wait read data valid only in the access phase
    always_comb
    begin
        PRDATA = '0;
        if (rd_access)
        begin
            case (reg_idx)
                REG_PADDIR:
                begin
                    PRDATA = cfg_q.dir;
                end
                REG_GPIOEN:
                begin
                    PRDATA = cfg_q.en;
                end
                REG_PADIN:
                begin
                    PRDATA = held_in;  // Third synchronizer stage
                end
                REG_PADOUT:
                begin
                    PRDATA = cfg_q.out;
                end
                REG_INTEN:
                begin
                    PRDATA = cfg_q.inten;
                end
                REG_INTTYPE_LO:
                begin
                    PRDATA = cfg_q.inttype[15:0];
                end
                REG_INTTYPE_HI:
                begin
                    PRDATA = cfg_q.inttype[31:16];
                end
                REG_INTSTATUS:
                begin
                    PRDATA = status;  // Value before the clear
                end
                default:
                begin
                    PRDATA = '0;
                end
            endcase
        end
    end

    // Clear strobe follows a read setup phase and lasts one cycle
    a_status_rd_in_read: assert property (
        @(posedge HCLK) disable iff (!HRESETn)
        status_rd |-> $past(PSEL && !PENABLE && !PWRITE) ##1 !status_rd
    );

endmodule

//--- design/gpio_in_sync.sv
// Per-pad three-stage input synchronizer with enable gating and edge detection for the GPIO
`timescale 1ns/10ps

module gpio_in_sync
    import gpio_pkg::*;
(
    input  logic     HCLK,
    input  logic     HRESETn,
    input  pad_vec_t gpio_in,
    input  pad_vec_t en,
    output pad_vec_t sync_in,
    output pad_vec_t held_in,
    output pad_vec_t rise,
    output pad_vec_t fall
);

    pad_vec_t stage0;
    pad_vec_t stage1;
    pad_vec_t stage2;

    always_ff @(posedge HCLK or negedge HRESETn)
    begin
        if (!HRESETn)
        begin
            stage0 <= '0;
            stage1 <= '0;
            stage2 <= '0;
        end
        else
        begin
            for (int i = 0; i < PAD_NUM; i++)
            begin
                if (en[i])  // Disabled pads freeze all stages
                begin
                    stage0[i] <= gpio_in[i];
                    stage1[i] <= stage0[i];
                    stage2[i] <= stage1[i];
                end
            end
        end
    end

    assign sync_in = stage1;
    assign held_in = stage2;
    assign rise    = stage1 & ~stage2;
    assign fall    = ~stage1 & stage2;

    // A pad that was disabled on the last edge did not move its sync stage
    a_disabled_hold: assert property (
        @(posedge HCLK) disable iff (!HRESETn)
        ((sync_in ^ $past(sync_in)) & ~$past(en)) == '0
    );

endmodule

//--- design/gpio_irq.sv
// GPIO interrupt logic: matches edges to each pad's type and keeps the clear-on-read status
`timescale 1ns/10ps

module gpio_irq
    import gpio_pkg::*;
(
    input  logic      HCLK,
    input  logic      HRESETn,
    input  gpio_cfg_t cfg,
    input  pad_vec_t  rise,
    input  pad_vec_t  fall,
    input  logic      status_rd,
    output pad_vec_t  status,
    output logic      interrupt
);

    pad_vec_t type_hit;
    pad_vec_t irq_match;
    pad_vec_t status_q;

    always_comb
    begin
        for (int i = 0; i < PAD_NUM; i++)
        begin
            case (cfg.inttype[i])
                INT_FALL: type_hit[i] = fall[i];
                INT_RISE: type_hit[i] = rise[i];
                INT_BOTH: type_hit[i] = rise[i] | fall[i];
                default:  type_hit[i] = 1'b0;  // Code 11 is off
            endcase
        end
    end

    assign irq_match = type_hit & cfg.en & cfg.inten;
    assign interrupt = |irq_match;

    always_ff @(posedge HCLK or negedge HRESETn)
    begin
        if (!HRESETn)
        begin
            status_q <= '0;
        end
        else if (interrupt)
        begin
            status_q <= status_q | irq_match;  // New events win over a clear
        end
        else if (status_rd)
        begin
            status_q <= '0;
        end
    end

    assign status = status_q;

    // Only a pad that is both enabled and unmasked can raise the line
    a_irq_source: assert property (
        @(posedge HCLK) disable iff (!HRESETn)
        interrupt |-> |(cfg.en & cfg.inten)
    );

endmodule

//--- design/gpio_pkg.sv
// Shared GPIO constants, register map and configuration types, imported by every design module
package gpio_pkg;

    localparam int PAD_NUM        = 32;
    localparam int APB_ADDR_WIDTH = 12;
    localparam int REG_ADDR_WIDTH = 5;  // Word index taken from PADDR[6:2]

    localparam logic [REG_ADDR_WIDTH-1:0] REG_PADDIR     = 5'd0;  // 0x00
    localparam logic [REG_ADDR_WIDTH-1:0] REG_GPIOEN     = 5'd1;  // 0x04
    localparam logic [REG_ADDR_WIDTH-1:0] REG_PADIN      = 5'd2;  // 0x08
    localparam logic [REG_ADDR_WIDTH-1:0] REG_PADOUT     = 5'd3;  // 0x0C
    localparam logic [REG_ADDR_WIDTH-1:0] REG_PADOUTSET  = 5'd4;  // 0x10
    localparam logic [REG_ADDR_WIDTH-1:0] REG_PADOUTCLR  = 5'd5;  // 0x14
    localparam logic [REG_ADDR_WIDTH-1:0] REG_INTEN      = 5'd6;  // 0x18
    localparam logic [REG_ADDR_WIDTH-1:0] REG_INTTYPE_LO = 5'd7;  // 0x1C, pads 0-15
    localparam logic [REG_ADDR_WIDTH-1:0] REG_INTTYPE_HI = 5'd8;  // 0x20, pads 16-31
    localparam logic [REG_ADDR_WIDTH-1:0] REG_INTSTATUS  = 5'd9;  // 0x24

    // Interrupt type per pad; code 2'b11 never fires
    localparam logic [1:0] INT_FALL = 2'b00;
    localparam logic [1:0] INT_RISE = 2'b01;
    localparam logic [1:0] INT_BOTH = 2'b10;

    typedef logic [PAD_NUM-1:0] pad_vec_t;

    typedef logic [1:0] int_type_t;

    typedef struct packed {
        pad_vec_t                  dir;
        pad_vec_t                  en;
        pad_vec_t                  out;
        pad_vec_t                  inten;
        int_type_t [PAD_NUM-1:0]   inttype;  // Pad 0 in bits 1:0
    } gpio_cfg_t;

endpackage

//--- run_sim.sh
#!/bin/sh
# Builds the GPIO testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_apb_gpio -f compile.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vtb_apb_gpio)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -q "^STATUS: PASS$"; then
    exit 0
fi
exit 1

//--- sim/tb_apb_gpio.sv
// Directed testbench for the APB GPIO, built from compile.f with tb_apb_gpio as top
`timescale 1ns/10ps

module tb_apb_gpio
    import gpio_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 2000;  // Tests take about 300 cycles

    logic                      HCLK;
    logic                      HRESETn;
    logic [APB_ADDR_WIDTH-1:0] PADDR;
    pad_vec_t                  PWDATA;
    logic                      PWRITE;
    logic                      PSEL;
    logic                      PENABLE;
    pad_vec_t                  PRDATA;
    logic                      PREADY;
    logic                      PSLVERR;
    pad_vec_t                  gpio_in;
    pad_vec_t                  gpio_in_sync;
    pad_vec_t                  gpio_out;
    pad_vec_t                  gpio_dir;
    logic                      interrupt;

    integer seed;
    int     errors = 0;
    int     checks = 0;
    int     cycles = 0;

    apb_gpio dut_i (.*);

    initial
    begin
        HCLK = 1'b0;
        forever #2 HCLK = ~HCLK;
    end

    always @(posedge HCLK)
    begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES)
        begin
            $display("Timeout after %0d cycles, the tests did not finish", cycles);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    task automatic check_eq(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
        checks++;
        if (expected !== actual)
        begin
            errors++;
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic idle(input int n);
        repeat (n) @(posedge HCLK);
        #1;
    endtask

    // Setup then access phase, write lands on the closing edge
    task automatic apb_write(input logic [REG_ADDR_WIDTH-1:0] idx, input pad_vec_t data);
        @(posedge HCLK);
        #1;
        PADDR   = {5'b0, idx, 2'b00};
        PWDATA  = data;
        PWRITE  = 1'b1;
        PSEL    = 1'b1;
        PENABLE = 1'b0;
        @(posedge HCLK);
        #1;
        PENABLE = 1'b1;
        @(posedge HCLK);
        #1;
        PSEL    = 1'b0;
        PENABLE = 1'b0;
        PWRITE  = 1'b0;
    endtask

    task automatic apb_read(input logic [REG_ADDR_WIDTH-1:0] idx, output pad_vec_t data);
        @(posedge HCLK);
        #1;
        PADDR   = {5'b0, idx, 2'b00};
        PWRITE  = 1'b0;
        PSEL    = 1'b1;
        PENABLE = 1'b0;
        @(posedge HCLK);
        #1;
        PENABLE = 1'b1;
        #1;
        data = PRDATA;  // Mid-cycle, well away from the edge
        @(posedge HCLK);
        #1;
        PSEL    = 1'b0;
        PENABLE = 1'b0;
    endtask

    task automatic test_reset();
        pad_vec_t rd;
        for (int i = 0; i <= int'(REG_INTSTATUS); i++)
        begin
            apb_read(5'(i), rd);
            check_eq($sformatf("reset reg %0d", i), '0, rd);
        end
        check_eq("reset gpio_out", '0, gpio_out);
        check_eq("reset gpio_dir", '0, gpio_dir);
        check_eq("reset interrupt", '0, {31'b0, interrupt});
        check_eq("pready", 32'd1, {31'b0, PREADY});
        check_eq("pslverr", '0, {31'b0, PSLVERR});
    endtask

    task automatic test_readback();
        logic [REG_ADDR_WIDTH-1:0] idx [6];
        pad_vec_t                  val [6];
        pad_vec_t                  rd;
        idx = '{REG_PADDIR, REG_GPIOEN, REG_PADOUT, REG_INTEN, REG_INTTYPE_LO, REG_INTTYPE_HI};
        for (int i = 0; i < 6; i++)
        begin
            val[i] = $random(seed);
            apb_write(idx[i], val[i]);
        end
        for (int i = 0; i < 6; i++)
        begin
            apb_read(idx[i], rd);
            check_eq($sformatf("readback reg %0d", idx[i]), val[i], rd);
        end
        check_eq("readback gpio_dir", val[0], gpio_dir);
        check_eq("readback gpio_out", val[2], gpio_out);
        apb_read(5'd12, rd);  // Hole in the map
        check_eq("unmapped read", '0, rd);
        apb_write(REG_INTEN, '0);
    endtask

    task automatic test_set_clear();
        pad_vec_t model;
        pad_vec_t mask;
        pad_vec_t rd;
        model = $random(seed);
        apb_write(REG_PADOUT, model);
        mask = $random(seed);
        apb_write(REG_PADOUTSET, mask);
        model = model | mask;
        apb_read(REG_PADOUT, rd);
        check_eq("padout set", model, rd);
        mask = $random(seed);
        apb_write(REG_PADOUTCLR, mask);
        model = model & ~mask;
        apb_read(REG_PADOUT, rd);
        check_eq("padout clear", model, rd);
        check_eq("gpio_out after clear", model, gpio_out);
    endtask

    task automatic test_input_path();
        pad_vec_t first;
        pad_vec_t second;
        pad_vec_t en_mask;
        pad_vec_t expected;
        pad_vec_t rd;
        apb_write(REG_GPIOEN, '1);
        first   = $random(seed);
        gpio_in = first;
        idle(4);
        apb_read(REG_PADIN, rd);
        check_eq("padin all enabled", first, rd);
        en_mask = $random(seed);
        apb_write(REG_GPIOEN, en_mask);
        second  = $random(seed);
        gpio_in = second;
        idle(4);
        expected = (second & en_mask) | (first & ~en_mask);  // Disabled pads hold
        apb_read(REG_PADIN, rd);
        check_eq("padin partly enabled", expected, rd);
        check_eq("gpio_in_sync partly enabled", expected, gpio_in_sync);
    endtask

    // Looks for the interrupt line over four cycles after an input change
    task automatic watch_irq(output logic seen);
        seen = 1'b0;
        repeat (4)
        begin
            @(posedge HCLK);
            #2;
            if (interrupt)
            begin
                seen = 1'b1;
            end
        end
        @(posedge HCLK);
        #1;
    endtask

    task automatic test_interrupts();
        int         pads [4];
        logic [1:0] kinds [4];
        pad_vec_t   mask;
        pad_vec_t   type_lo;
        pad_vec_t   type_hi;
        pad_vec_t   model;
        pad_vec_t   rd;
        logic       fire;
        logic       seen;
        pads    = '{3, 9, 20, 27};
        kinds   = '{INT_FALL, INT_RISE, INT_BOTH, 2'b11};
        mask    = '0;
        type_lo = '1;  // Unused pads get code 11
        type_hi = '1;
        for (int j = 0; j < 4; j++)
        begin
            mask[pads[j]] = 1'b1;
            if (pads[j] < 16)
            begin
                type_lo[2*pads[j] +: 2] = kinds[j];
            end
            else
            begin
                type_hi[2*(pads[j]-16) +: 2] = kinds[j];
            end
        end
        apb_write(REG_INTEN, '0);
        apb_write(REG_INTTYPE_LO, type_lo);
        apb_write(REG_INTTYPE_HI, type_hi);
        gpio_in = '0;
        apb_write(REG_GPIOEN, mask);
        idle(4);  // Flush old pad values while masked
        apb_write(REG_INTEN, mask);
        apb_read(REG_INTSTATUS, rd);
        check_eq("status before edges", '0, rd);
        for (int j = 0; j < 4; j++)
        begin
            model = '0;
            for (int e = 0; e < 2; e++)
            begin
                gpio_in[pads[j]] = (e == 0);  // Rise, then fall
                if (e == 0)
                begin
                    fire = (kinds[j] == INT_RISE) || (kinds[j] == INT_BOTH);
                end
                else
                begin
                    fire = (kinds[j] == INT_FALL) || (kinds[j] == INT_BOTH);
                end
                watch_irq(seen);
                check_eq($sformatf("irq pad %0d edge %0d", pads[j], e),
                         {31'b0, fire}, {31'b0, seen});
                if (fire)
                begin
                    model[pads[j]] = 1'b1;
                end
            end
            apb_read(REG_INTSTATUS, rd);
            check_eq($sformatf("status pad %0d", pads[j]), model, rd);
            apb_read(REG_INTSTATUS, rd);
            check_eq($sformatf("status cleared pad %0d", pads[j]), '0, rd);
        end
    endtask

    initial
    begin
        seed    = 32'h497f8652;
        HRESETn = 1'b0;
        PADDR   = '0;
        PWDATA  = '0;
        PWRITE  = 1'b0;
        PSEL    = 1'b0;
        PENABLE = 1'b0;
        gpio_in = '0;
        repeat (3) @(posedge HCLK);
        #1;
        HRESETn = 1'b1;
        test_reset();
        test_readback();
        test_set_clear();
        test_input_path();
        test_interrupts();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
        begin
            $display("STATUS: PASS");
        end
        else
        begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule
